/* mem_monitor.f */
hw/serial_pkg.sv
hw/sram_pkg.sv
hw/uart_rx.sv
hw/uart_tx.sv
hw/monitor_ctrl.sv
hw/sram_ctrl.sv
hw/mem_monitor_top.sv
tb/sram_model.sv
tb/tb_mem_monitor.sv

/* run_sim.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert --top-module tb_mem_monitor -f mem_monitor.f

./obj_dir/Vtb_mem_monitor > sim.log 2>&1
cat sim.log

if grep -q "Checks failed" sim.log; then
    exit 1
fi
exit 0

/* tb/tb_mem_monitor.sv */
`timescale 1ns/100ps
module tb_mem_monitor import serial_pkg::*, sram_pkg::*;;

    localparam int CLKS_PER_BIT = 16;
    localparam int SRAM_WAIT    = 3;
    // long enough to cover a whole read command before the reply starts
    localparam int REPLY_LIMIT  = 80 * CLKS_PER_BIT;

    logic       clk_in;
    logic       reset;
    logic       rxd;
    logic       txd;
    wire [31:0] ram_data;
    sram_addr_t ram_addr;
    logic       ram_ce_n;
    logic       ram_oe_n;
    logic       ram_we_n;

    logic [15:0] lfsr_q;
    string       cur_test;
    int          check_count;
    int          error_count;
    int          test_count;
    int          test_errors;
    uart_byte_t  reply_bytes [4];
    logic [31:0] wr_addr [8];
    sram_data_t  wr_data [8];
    sram_addr_t  wr_pin_addr;
    sram_addr_t  rd_pin_addr;

    mem_monitor_top #(
        .CLKS_PER_BIT(CLKS_PER_BIT),
        .SRAM_WAIT   (SRAM_WAIT)
    ) u_mem_monitor_top (
        .clk_in  (clk_in),
        .reset   (reset),
        .rxd     (rxd),
        .txd     (txd),
        .ram_data(ram_data),
        .ram_addr(ram_addr),
        .ram_ce_n(ram_ce_n),
        .ram_oe_n(ram_oe_n),
        .ram_we_n(ram_we_n)
    );

    sram_model u_sram_model (
        .ram_data(ram_data),
        .ram_addr(ram_addr),
        .ram_ce_n(ram_ce_n),
        .ram_oe_n(ram_oe_n),
        .ram_we_n(ram_we_n)
    );

    always #10 clk_in = ~clk_in;

    // addresses seen on the pins during write and read strobes
    always @(negedge clk_in) begin
        if (!ram_ce_n && !ram_we_n) begin
            wr_pin_addr <= ram_addr;
        end
        if (!ram_ce_n && !ram_oe_n) begin
            rd_pin_addr <= ram_addr;
        end
    end

    // fibonacci lfsr, taps 16 14 13 11
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    task automatic rand_bits(input int nbits, output logic [31:0] val);
        val = '0;
        for (int i = 0; i < nbits; i++) begin
            lfsr_q = lfsr_next(lfsr_q);
            val    = {val[30:0], lfsr_q[0]};
        end
    endtask

    task automatic check_byte(input uart_byte_t expected, input uart_byte_t actual);
        check_count++;
        if (actual !== expected) begin
            error_count++;
            $display("ERROR %s: expected %h, actual %h", cur_test, expected, actual);
        end
    endtask

    task automatic check_word(input sram_data_t expected, input sram_data_t actual);
        check_count++;
        if (actual !== expected) begin
            error_count++;
            $display("ERROR %s: expected %h, actual %h", cur_test, expected, actual);
        end
    endtask

    task automatic check_addr(input sram_addr_t expected, input sram_addr_t actual);
        check_count++;
        if (actual !== expected) begin
            error_count++;
            $display("ERROR %s: expected %h, actual %h", cur_test, expected, actual);
        end
    endtask

    task automatic check_pin(input string pin, input logic expected, input logic actual);
        check_count++;
        if (actual !== expected) begin
            error_count++;
            $display("ERROR %s: %s expected %b, actual %b", cur_test, pin, expected, actual);
        end
    endtask

    task automatic report_failure(input string msg);
        error_count++;
        $display("%s: %s", cur_test, msg);
    endtask

    task automatic start_test(input string name);
        cur_test    = name;
        test_errors = error_count;
        test_count++;
    endtask

    task automatic end_test();
        if (error_count == test_errors) begin
            $display("%s: ok", cur_test);
        end else begin
            $display("%s: failed with %0d errors", cur_test, error_count - test_errors);
        end
    endtask

    // start bit, data lsb first, stop bit
    task automatic send_byte(input uart_byte_t b);
        logic [9:0] frame;
        frame = {1'b1, b, 1'b0};
        for (int i = 0; i < 10; i++) begin
            rxd = frame[i];
            repeat (CLKS_PER_BIT) @(negedge clk_in);
        end
    endtask

    task automatic send_word(input logic [31:0] w);
        for (int i = 0; i < 4; i++) begin
            send_byte(w[8*i +: 8]);
        end
    endtask

    task automatic recv_byte(output uart_byte_t b, output logic ok);
        int waited;
        waited = 0;
        ok     = 1'b1;
        b      = '0;
        while (txd !== 1'b0 && waited < REPLY_LIMIT) begin
            @(negedge clk_in);
            waited++;
        end
        if (txd !== 1'b0) begin
            report_failure("no start bit on txd before the timeout");
            ok = 1'b0;
        end else begin
            repeat (CLKS_PER_BIT / 2) @(negedge clk_in);
            if (txd !== 1'b0) begin
                report_failure("start bit on txd shorter than half a bit");
                ok = 1'b0;
            end else begin
                // sample at the bit centers
                for (int i = 0; i < 8; i++) begin
                    repeat (CLKS_PER_BIT) @(negedge clk_in);
                    b[i] = txd;
                end
                repeat (CLKS_PER_BIT) @(negedge clk_in);
                if (txd !== 1'b1) begin
                    report_failure("stop bit on txd is low");
                    ok = 1'b0;
                end
            end
        end
    endtask

    task automatic write_word(input logic [31:0] addr, input sram_data_t data);
        send_byte(CMD_WRITE);
        send_word(addr);
        send_word(data);
    endtask

    // reply may start before the last stop bit ends, so listen in parallel
    task automatic read_word(input logic [31:0] addr, output sram_data_t data);
        logic ok;
        ok = 1'b1;
        for (int i = 0; i < 4; i++) begin
            reply_bytes[i] = '0;
        end
        fork
            begin
                send_byte(CMD_READ);
                send_word(addr);
            end
            begin
                for (int i = 0; i < 4; i++) begin
                    if (ok) begin
                        recv_byte(reply_bytes[i], ok);
                    end
                end
            end
        join
        data = {reply_bytes[3], reply_bytes[2], reply_bytes[1], reply_bytes[0]};
    endtask

    // the memory holds 1024 words, so low address bits alias
    function automatic sram_data_t expected_at(input int k);
        sram_data_t val;
        val = '0;
        for (int i = 0; i < 8; i++) begin
            if (wr_addr[i][9:0] == wr_addr[k][9:0]) begin
                val = wr_data[i];
            end
        end
        return val;
    endfunction

    task automatic reset_pins_idle();
        start_test("reset_state");
        for (int i = 0; i < 50; i++) begin
            @(negedge clk_in);
            check_pin("txd", 1'b1, txd);
            check_pin("ram_ce_n", 1'b1, ram_ce_n);
            check_pin("ram_oe_n", 1'b1, ram_oe_n);
            check_pin("ram_we_n", 1'b1, ram_we_n);
        end
        end_test();
    endtask

    task automatic single_write_read();
        sram_data_t got;
        start_test("write_read");
        write_word(32'h0000_5566, 32'h3403_eeff);
        read_word(32'h0000_5566, got);
        check_addr(20'h0_5566, wr_pin_addr);
        check_addr(20'h0_5566, rd_pin_addr);
        check_byte(8'hff, reply_bytes[0]);
        check_byte(8'hee, reply_bytes[1]);
        check_byte(8'h03, reply_bytes[2]);
        check_byte(8'h34, reply_bytes[3]);
        check_word(32'h3403_eeff, got);
        end_test();
    endtask

    task automatic random_pairs_readback();
        logic [31:0] r;
        sram_data_t  got;
        int          k;
        start_test("random_pairs");
        for (int i = 0; i < 8; i++) begin
            rand_bits(20, r);
            wr_addr[i] = r;
            rand_bits(32, r);
            wr_data[i] = r;
            write_word(wr_addr[i], wr_data[i]);
        end
        // read back in a shuffled order
        for (int j = 0; j < 8; j++) begin
            k = (3 * j + 1) % 8;
            read_word(wr_addr[k], got);
            check_word(expected_at(k), got);
        end
        end_test();
    endtask

    task automatic unknown_cmd_dropped();
        logic        quiet;
        logic [31:0] d;
        sram_data_t  got;
        start_test("unknown_command");
        send_byte(8'h34);
        quiet = 1'b1;
        for (int i = 0; i < 20 * CLKS_PER_BIT; i++) begin
            @(negedge clk_in);
            if (txd !== 1'b1) begin
                quiet = 1'b0;
            end
        end
        if (!quiet) begin
            report_failure("txd went low after an unknown command byte");
        end
        rand_bits(32, d);
        write_word(32'h0000_0200, d);
        read_word(32'h0000_0200, got);
        check_word(d, got);
        end_test();
    endtask

    task automatic upper_addr_dropped();
        logic [31:0] d;
        sram_data_t  got;
        start_test("addr_truncation");
        rand_bits(32, d);
        write_word(32'hfff1_2345, d);
        read_word(32'h0001_2345, got);
        check_addr(20'h1_2345, wr_pin_addr);
        check_addr(20'h1_2345, rd_pin_addr);
        check_word(d, got);
        end_test();
    endtask

    task automatic repeated_reads();
        logic [31:0] d0;
        logic [31:0] d1;
        sram_data_t  first;
        sram_data_t  second;
        sram_data_t  third;
        start_test("repeat_reads");
        rand_bits(32, d0);
        rand_bits(32, d1);
        if (d1 == d0) begin
            d1 = ~d0;
        end
        write_word(32'h0000_0abc, d0);
        read_word(32'h0000_0abc, first);
        read_word(32'h0000_0abc, second);
        check_word(d0, first);
        check_word(d0, second);
        write_word(32'h0000_0abc, d1);
        read_word(32'h0000_0abc, third);
        check_word(d1, third);
        end_test();
    endtask

    initial begin
        clk_in      = 1'b0;
        reset       = 1'b1;
        rxd         = 1'b1;
        lfsr_q      = 16'd72;
        check_count = 0;
        error_count = 0;
        test_count  = 0;
        test_errors = 0;
        wr_pin_addr = '0;
        rd_pin_addr = '0;
        repeat (16) @(negedge clk_in);
        reset = 1'b0;

        reset_pins_idle();
        single_write_read();
        random_pairs_readback();
        unknown_cmd_dropped();
        upper_addr_dropped();
        repeated_reads();

        $display("tests: %0d, checks: %0d, errors: %0d", test_count, check_count, error_count);
        if (error_count == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

/* tb/sram_model.sv */
`timescale 1ns/100ps
module sram_model import sram_pkg::*; (
    inout  sram_data_t ram_data,
    input  sram_addr_t ram_addr,
    input  logic       ram_ce_n,
    input  logic       ram_oe_n,
    input  logic       ram_we_n
);

    localparam int DEPTH = 1024;

    sram_data_t mem [DEPTH];

    // each word starts out distinct, built from its full index
    initial begin
        for (int i = 0; i < DEPTH; i++) begin
            mem[i] = {~i[9:0], 2'b10, i[9:0], 10'h155};
        end
    end

    // write data is taken once the bus has settled
    always @(negedge ram_we_n) begin
        #1;
        if (!ram_ce_n && !ram_we_n) begin
            mem[ram_addr[9:0]] = ram_data;
        end
    end

    // low address bits select the word, upper bits alias
    assign ram_data = (!ram_ce_n && !ram_oe_n && ram_we_n) ? mem[ram_addr[9:0]] : 'z;

endmodule

/* hw/mem_monitor_top.sv */
`timescale 1ns/100ps
module mem_monitor_top import serial_pkg::*, sram_pkg::*; #(
    parameter int CLKS_PER_BIT = 16,
    parameter int SRAM_WAIT    = 3
) (
    input  logic       clk_in,
    input  logic       reset,
    input  logic       rxd,
    output logic       txd,
    inout  sram_data_t ram_data,
    output sram_addr_t ram_addr,
    output logic       ram_ce_n,
    output logic       ram_oe_n,
    output logic       ram_we_n
);

    uart_byte_t rx_byte;
    logic       rx_valid;
    uart_byte_t tx_byte;
    logic       tx_start;
    logic       tx_busy;
    sram_req_t  req;
    logic       req_valid;
    sram_data_t rdata;
    logic       done;

    uart_rx #(
        .CLKS_PER_BIT(CLKS_PER_BIT)
    ) u_uart_rx (
        .clk_in  (clk_in),
        .reset   (reset),
        .rxd     (rxd),
        .rx_byte (rx_byte),
        .rx_valid(rx_valid)
    );

    uart_tx #(
        .CLKS_PER_BIT(CLKS_PER_BIT)
    ) u_uart_tx (
        .clk_in  (clk_in),
        .reset   (reset),
        .tx_byte (tx_byte),
        .tx_start(tx_start),
        .txd     (txd),
        .tx_busy (tx_busy)
    );

    monitor_ctrl u_monitor_ctrl (
        .clk_in   (clk_in),
        .reset    (reset),
        .rx_byte  (rx_byte),
        .rx_valid (rx_valid),
        .tx_byte  (tx_byte),
        .tx_start (tx_start),
        .tx_busy  (tx_busy),
        .req      (req),
        .req_valid(req_valid),
        .rdata    (rdata),
        .done     (done)
    );

    sram_ctrl #(
        .SRAM_WAIT(SRAM_WAIT)
    ) u_sram_ctrl (
        .clk_in   (clk_in),
        .reset    (reset),
        .req      (req),
        .req_valid(req_valid),
        .rdata    (rdata),
        .done     (done),
        .ram_data (ram_data),
        .ram_addr (ram_addr),
        .ram_ce_n (ram_ce_n),
        .ram_oe_n (ram_oe_n),
        .ram_we_n (ram_we_n)
    );

endmodule

/* hw/sram_ctrl.sv */
`timescale 1ns/100ps
module sram_ctrl import sram_pkg::*; #(
    parameter int SRAM_WAIT = 3
) (
    input  logic       clk_in,
    input  logic       reset,
    input  sram_req_t  req,
    input  logic       req_valid,
    output sram_data_t rdata,
    output logic       done,
    inout  sram_data_t ram_data,
    output sram_addr_t ram_addr,
    output logic       ram_ce_n,
    output logic       ram_oe_n,
    output logic       ram_we_n
);

    localparam int WAIT_W = $clog2(SRAM_WAIT + 1);
    localparam logic [WAIT_W-1:0] WAIT_LAST = WAIT_W'(SRAM_WAIT - 1);

    typedef enum logic [1:0] {
        SR_IDLE,
        SR_ACCESS,
        SR_DONE
    } sram_state_t;

    sram_state_t       state;
    logic [WAIT_W-1:0] wait_cnt;
    sram_req_t         req_q;
    logic              access;

    always_ff @(posedge clk_in) begin
        if (reset) begin
            state    <= SR_IDLE;
            wait_cnt <= '0;
        end else begin
            case (state)
                SR_IDLE: begin
                    wait_cnt <= '0;
                    if (req_valid) begin
                        state <= SR_ACCESS;
                    end
                end
                SR_ACCESS: begin
                    if (wait_cnt == WAIT_LAST) begin
                        state <= SR_DONE;
                    end else begin
                        wait_cnt <= wait_cnt + 1'b1;
                    end
                end
                default: state <= SR_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk_in) begin
        if (state == SR_IDLE && req_valid) begin
            req_q <= req;
        end
        // read data is taken on the last oe_n low cycle
        if (access && wait_cnt == WAIT_LAST && !req_q.we) begin
            rdata <= ram_data;
        end
    end

    assign access   = (state == SR_ACCESS);
    assign done     = (state == SR_DONE);
    assign ram_addr = req_q.addr;
    assign ram_ce_n = !access;
    assign ram_oe_n = !(access && !req_q.we);
    assign ram_we_n = !(access && req_q.we);

    // bus driven only while we_n is low
    assign ram_data = (access && req_q.we) ? req_q.wdata : 'z;

    // a request arriving mid-access would be lost
    a_req_when_idle: assert property (@(posedge clk_in) disable iff (reset)
        req_valid |-> state == SR_IDLE);

endmodule

/* hw/monitor_ctrl.sv */
`timescale 1ns/100ps
module monitor_ctrl import serial_pkg::*, sram_pkg::*; (
    input  logic       clk_in,
    input  logic       reset,
    input  uart_byte_t rx_byte,
    input  logic       rx_valid,
    output uart_byte_t tx_byte,
    output logic       tx_start,
    input  logic       tx_busy,
    output sram_req_t  req,
    output logic       req_valid,
    input  sram_data_t rdata,
    input  logic       done
);

    mon_state_t  state;
    logic [1:0]  byte_cnt;
    logic        is_write;
    logic        pending;
    logic [31:0] addr_word;
    sram_data_t  data_word;
    sram_data_t  reply_q;
    logic        send_now;

    // one reply byte per idle transmitter
    assign send_now = (state == ST_SEND_REPLY) && !tx_busy && !tx_start;

    always_ff @(posedge clk_in) begin
        if (reset) begin
            state     <= ST_IDLE;
            byte_cnt  <= '0;
            is_write  <= 1'b0;
            req_valid <= 1'b0;
            tx_start  <= 1'b0;
            pending   <= 1'b0;
        end else begin
            req_valid <= 1'b0;
            tx_start  <= 1'b0;
            if (req_valid) begin
                pending <= 1'b1;
            end else if (done) begin
                pending <= 1'b0;
            end
            case (state)
                ST_IDLE: begin
                    byte_cnt <= '0;
                    if (rx_valid) begin
                        case (cmd_t'(rx_byte))
                            CMD_WRITE: begin
                                is_write <= 1'b1;
                                state    <= ST_GET_ADDR;
                            end
                            CMD_READ: begin
                                is_write <= 1'b0;
                                state    <= ST_GET_ADDR;
                            end
                            // unknown command, wait for the next one
                            default: state <= ST_IDLE;
                        endcase
                    end
                end
                ST_GET_ADDR: begin
                    if (rx_valid) begin
                        byte_cnt <= byte_cnt + 1'b1;
                        if (byte_cnt == 2'd3 && is_write) begin
                            state <= ST_GET_DATA;
                        end else if (byte_cnt == 2'd3) begin
                            req_valid <= 1'b1;
                            state     <= ST_MEM_ACCESS;
                        end
                    end
                end
                ST_GET_DATA: begin
                    if (rx_valid) begin
                        byte_cnt <= byte_cnt + 1'b1;
                        if (byte_cnt == 2'd3) begin
                            req_valid <= 1'b1;
                            state     <= ST_MEM_ACCESS;
                        end
                    end
                end
                ST_MEM_ACCESS: begin
                    if (done) begin
                        byte_cnt <= '0;
                        state    <= is_write ? ST_IDLE : ST_SEND_REPLY;
                    end
                end
                ST_SEND_REPLY: begin
                    if (send_now) begin
                        tx_start <= 1'b1;
                        byte_cnt <= byte_cnt + 1'b1;
                        if (byte_cnt == 2'd3) begin
                            state <= ST_IDLE;
                        end
                    end
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

    // words arrive lsb first, so shift in from the top
    always_ff @(posedge clk_in) begin
        if (rx_valid && state == ST_GET_ADDR) begin
            addr_word <= {rx_byte, addr_word[31:8]};
        end
        if (rx_valid && state == ST_GET_DATA) begin
            data_word <= {rx_byte, data_word[31:8]};
        end
        if (state == ST_MEM_ACCESS && done) begin
            reply_q <= rdata;
        end else if (send_now) begin
            tx_byte <= reply_q[7:0];
            reply_q <= {8'h00, reply_q[31:8]};
        end
    end

    // upper address bits are dropped here
    assign req = '{we: is_write, addr: addr_word[19:0], wdata: data_word};

    // sram_ctrl takes a request only when idle
    a_one_req_in_flight: assert property (@(posedge clk_in) disable iff (reset)
        pending |-> !req_valid);

endmodule

/* hw/uart_tx.sv */
`timescale 1ns/100ps
module uart_tx import serial_pkg::*; #(
    parameter int CLKS_PER_BIT = 16
) (
    input  logic       clk_in,
    input  logic       reset,
    input  uart_byte_t tx_byte,
    input  logic       tx_start,
    output logic       txd,
    output logic       tx_busy
);

    localparam int CNT_W = $clog2(CLKS_PER_BIT);
    localparam logic [CNT_W-1:0] BIT_LAST = CNT_W'(CLKS_PER_BIT - 1);

    logic [9:0]       frame_q;
    logic [CNT_W-1:0] clk_cnt;
    logic [3:0]       bit_idx;

    always_ff @(posedge clk_in) begin
        if (reset) begin
            frame_q <= '1;
            clk_cnt <= '0;
            bit_idx <= '0;
            tx_busy <= 1'b0;
        end else if (!tx_busy) begin
            if (tx_start) begin
                // stop bit, data lsb first, start bit
                frame_q <= {1'b1, tx_byte, 1'b0};
                clk_cnt <= '0;
                bit_idx <= '0;
                tx_busy <= 1'b1;
            end
        end else if (clk_cnt == BIT_LAST) begin
            clk_cnt <= '0;
            // ones shift in behind the frame so the line rests high
            frame_q <= {1'b1, frame_q[9:1]};
            if (bit_idx == 4'd9) begin
                tx_busy <= 1'b0;
            end else begin
                bit_idx <= bit_idx + 1'b1;
            end
        end else begin
            clk_cnt <= clk_cnt + 1'b1;
        end
    end

    assign txd = frame_q[0];

    // the controller must wait out the frame before the next byte
    a_no_start_while_busy: assert property (@(posedge clk_in) disable iff (reset)
        !(tx_start && tx_busy));

endmodule

/* hw/uart_rx.sv */
`timescale 1ns/100ps
module uart_rx import serial_pkg::*; #(
    parameter int CLKS_PER_BIT = 16
) (
    input  logic       clk_in,
    input  logic       reset,
    input  logic       rxd,
    output uart_byte_t rx_byte,
    output logic       rx_valid
);

    localparam int CNT_W = $clog2(CLKS_PER_BIT);
    localparam logic [CNT_W-1:0] BIT_LAST = CNT_W'(CLKS_PER_BIT - 1);
    localparam logic [CNT_W-1:0] HALF_BIT = CNT_W'(CLKS_PER_BIT / 2 - 1);

    typedef enum logic [1:0] {
        RX_IDLE,
        RX_START,
        RX_DATA,
        RX_STOP
    } rx_state_t;

    rx_state_t        state;
    logic             rxd_meta;
    logic             rxd_sync;
    logic [CNT_W-1:0] clk_cnt;
    logic [2:0]       bit_idx;
    uart_byte_t       shift_q;

    // two-flop synchronizer, line idles high
    always_ff @(posedge clk_in) begin
        if (reset) begin
            rxd_meta <= 1'b1;
            rxd_sync <= 1'b1;
        end else begin
            rxd_meta <= rxd;
            rxd_sync <= rxd_meta;
        end
    end

    always_ff @(posedge clk_in) begin
        if (reset) begin
            state    <= RX_IDLE;
            clk_cnt  <= '0;
            bit_idx  <= '0;
            rx_valid <= 1'b0;
        end else begin
            rx_valid <= 1'b0;
            case (state)
                RX_IDLE: begin
                    clk_cnt <= '0;
                    bit_idx <= '0;
                    if (!rxd_sync) begin
                        state <= RX_START;
                    end
                end
                RX_START: begin
                    // recheck at half a bit, a short pulse is a glitch
                    if (clk_cnt == HALF_BIT) begin
                        clk_cnt <= '0;
                        state   <= rxd_sync ? RX_IDLE : RX_DATA;
                    end else begin
                        clk_cnt <= clk_cnt + 1'b1;
                    end
                end
                RX_DATA: begin
                    if (clk_cnt == BIT_LAST) begin
                        clk_cnt <= '0;
                        bit_idx <= bit_idx + 1'b1;
                        if (bit_idx == 3'd7) begin
                            state <= RX_STOP;
                        end
                    end else begin
                        clk_cnt <= clk_cnt + 1'b1;
                    end
                end
                RX_STOP: begin
                    if (clk_cnt == BIT_LAST) begin
                        // framing error drops the byte
                        rx_valid <= rxd_sync;
                        state    <= RX_IDLE;
                    end else begin
                        clk_cnt <= clk_cnt + 1'b1;
                    end
                end
                default: state <= RX_IDLE;
            endcase
        end
    end

    // data bits arrive lsb first at the bit centers
    always_ff @(posedge clk_in) begin
        if (state == RX_DATA && clk_cnt == BIT_LAST) begin
            shift_q <= {rxd_sync, shift_q[7:1]};
        end
    end

    assign rx_byte = shift_q;

endmodule

/* hw/sram_pkg.sv */
package sram_pkg;

    // word address as seen on the base_ram pins
    typedef logic [19:0] sram_addr_t;

    // one 32-bit memory word
    typedef logic [31:0] sram_data_t;

    // one SRAM access, 53 bits
    typedef struct packed {
        logic       we;
        sram_addr_t addr;
        sram_data_t wdata;
    } sram_req_t;

endpackage

/* hw/serial_pkg.sv */
package serial_pkg;

    // one byte on the serial line
    typedef logic [7:0] uart_byte_t;

    // host command codes, each followed by little-endian words
    typedef enum logic [7:0] {
        CMD_WRITE = 8'h30,
        CMD_READ  = 8'h31
    } cmd_t;

    // monitor sequencer states
    typedef enum logic [2:0] {
        ST_IDLE,
        ST_GET_ADDR,
        ST_GET_DATA,
        ST_MEM_ACCESS,
        ST_SEND_REPLY
    } mon_state_t;

endpackage
